// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;                               // Data and address width
    localparam logic [xlen-1:0] vec_reset = 32'h0000_0000;  // First fetch address

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word, seen as R-type or as I-type fields
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm_hi;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;   // Register ops, also the S layout
        i_fields_t i;   // Immediate ops, loads and JALR
    } instr_t;

    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_auipc   = 7'b0010111;
    localparam logic [6:0] op_jal     = 7'b1101111;
    localparam logic [6:0] op_jalr    = 7'b1100111;
    localparam logic [6:0] op_branch  = 7'b1100011;
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;

    localparam logic [2:0] f3_add  = 3'b000;    // Also SUB
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;    // Also SRA
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [1:0] {
        st_fetch,
        st_div,
        st_mem_rd,
        st_mem_wr
    } state_t;

endpackage

`default_nettype wire

// File: div_if.sv
`default_nettype none

interface div_if;
    import rv_pkg::*;

    logic            start;         // One-cycle request pulse
    logic            is_signed;
    logic [xlen-1:0] dividend;
    logic [xlen-1:0] divisor;
    logic            busy;
    logic [xlen-1:0] quotient;      // Valid once busy falls
    logic [xlen-1:0] remainder;

    modport requester (
        output start, is_signed, dividend, divisor,
        input  busy, quotient, remainder
    );

    modport divider (
        input  start, is_signed, dividend, divisor,
        output busy, quotient, remainder
    );

endinterface

`default_nettype wire

// File: rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  logic                    clk,
    input  rv_pkg::instr_t          instr,
    input  logic [rv_pkg::xlen-1:0] rd_data,
    input  logic                    rd_wr,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rd_wr && instr.r.rd != 5'd0) begin  // x0 is never written
            regs[instr.r.rd] <= rd_data;
        end
    end

    // Asynchronous reads, x0 forced to zero
    assign rs1_data = (instr.r.rs1 == 5'd0) ? '0 : regs[instr.r.rs1];
    assign rs2_data = (instr.r.rs2 == 5'd0) ? '0 : regs[instr.r.rs2];

endmodule

`default_nettype wire

// File: rv_alu.sv
`default_nettype none

module rv_alu (
    input  rv_pkg::instr_t          instr,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    output logic [rv_pkg::xlen-1:0] alu_result,
    output logic [rv_pkg::xlen-1:0] sum,
    output logic                    take_branch
);
    import rv_pkg::*;

    logic            is_alu_imm;
    logic            is_alu_reg;
    logic            is_branch;
    logic            is_store;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] r_operand;
    logic [4:0]      shamt;
    logic [xlen-1:0] add;
    logic [xlen:0]   diff;
    logic            is_eq;
    logic            is_lt;
    logic            is_ltu;
    logic            shr_fill;
    logic [xlen:0]   shr_wide;
    logic [xlen-1:0] shl;

    assign is_alu_imm = instr.r.opcode == op_alu_imm;
    assign is_alu_reg = instr.r.opcode == op_alu_reg;
    assign is_branch  = instr.r.opcode == op_branch;
    assign is_store   = instr.r.opcode == op_store;

    // Same word, two field layouts
    assign imm_i = {{(xlen-12){instr.i.imm_hi[11]}}, instr.i.imm_hi};
    assign imm_s = {{(xlen-12){instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};

    ////////////////////////////////////////////////////////////////////////////
    // Operands, adders and shifters
    ////////////////////////////////////////////////////////////////////////////
    assign r_operand = (is_alu_reg || is_branch) ? rs2_data : imm_i;
    assign shamt     = is_alu_imm ? instr.r.rs2 : rs2_data[4:0];

    assign sum  = rs1_data + (is_store ? imm_s : imm_i);    // Load/store address, JALR target
    assign add  = rs1_data + r_operand;
    assign diff = {1'b0, rs1_data} - {1'b0, r_operand};     // MSB is the borrow

    assign is_eq  = diff[xlen-1:0] == '0;
    assign is_ltu = diff[xlen];
    assign is_lt  = (rs1_data[xlen-1] ^ r_operand[xlen-1]) ? rs1_data[xlen-1] : diff[xlen];

    assign shl      = rs1_data << shamt;
    assign shr_fill = instr.r.funct7[5] & rs1_data[xlen-1];    // SRA keeps the sign
    assign shr_wide = $signed({shr_fill, rs1_data}) >>> shamt;

    always_comb begin
        case (instr.r.funct3)
            f3_add:  alu_result = (is_alu_reg && instr.r.funct7[5]) ? diff[xlen-1:0] : add;
            f3_sll:  alu_result = shl;
            f3_slt:  alu_result = {{(xlen-1){1'b0}}, is_lt};
            f3_sltu: alu_result = {{(xlen-1){1'b0}}, is_ltu};
            f3_xor:  alu_result = rs1_data ^ r_operand;
            f3_srl:  alu_result = shr_wide[xlen-1:0];
            f3_or:   alu_result = rs1_data | r_operand;
            f3_and:  alu_result = rs1_data & r_operand;
        endcase
    end

    always_comb begin
        take_branch = 1'b0;
        if (is_branch) begin
            case (instr.r.funct3)
                f3_beq:  take_branch = is_eq;
                f3_bne:  take_branch = !is_eq;
                f3_blt:  take_branch = is_lt;
                f3_bge:  take_branch = !is_lt;
                f3_bltu: take_branch = is_ltu;
                f3_bgeu: take_branch = !is_ltu;
                default: take_branch = 1'b0;   // Reserved encodings fall through
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rv_divider.sv
`default_nettype none

module rv_divider (
    input logic   clk,
    input logic   reset,
    div_if.divider div
);
    import rv_pkg::*;

    logic [xlen-1:0]   mask;        // One-hot quotient bit, doubles as step counter
    logic [xlen-1:0]   rem_acc;
    logic [xlen-1:0]   quo_acc;
    logic [2*xlen-2:0] dvsr;
    logic              neg_q;
    logic              neg_r;
    logic [xlen-1:0]   abs_a;
    logic [xlen-1:0]   abs_b;
    logic              fixup;

    assign abs_a = (div.is_signed && div.dividend[xlen-1]) ? -div.dividend : div.dividend;
    assign abs_b = (div.is_signed && div.divisor[xlen-1])  ? -div.divisor  : div.divisor;
    assign fixup = div.busy && mask == '0;

    ////////////////////////////////////////////////////////////////////////////
    // Step control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            div.busy <= 1'b0;
            mask     <= '0;
        end else if (div.start) begin
            div.busy <= 1'b1;
            mask     <= {1'b1, {(xlen-1){1'b0}}};
        end else if (fixup) begin
            div.busy <= 1'b0;                   // 32 steps done, signs applied now
        end else if (div.busy) begin
            mask     <= mask >> 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (div.start) begin
            rem_acc <= abs_a;
            dvsr    <= {abs_b, {(xlen-1){1'b0}}};
            quo_acc <= '0;
            neg_q   <= div.is_signed && (div.dividend[xlen-1] != div.divisor[xlen-1])
                       && div.divisor != '0;    // Zero divisor keeps all ones
            neg_r   <= div.is_signed && div.dividend[xlen-1];
        end else if (fixup) begin
            div.quotient  <= neg_q ? -quo_acc : quo_acc;
            div.remainder <= neg_r ? -rem_acc : rem_acc;
        end else if (div.busy) begin
            if (dvsr <= {{(xlen-1){1'b0}}, rem_acc}) begin
                rem_acc <= rem_acc - dvsr[xlen-1:0];
                quo_acc <= quo_acc | mask;
            end
            dvsr <= dvsr >> 1;
        end
    end

endmodule

`default_nettype wire

// File: rv_control.sv
`default_nettype none

module rv_control (
    input  logic                    clk,
    input  logic                    reset,
    output rv_pkg::instr_t          instr,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic [rv_pkg::xlen-1:0] alu_result,
    input  logic [rv_pkg::xlen-1:0] sum,
    input  logic                    take_branch,
    output logic [rv_pkg::xlen-1:0] rd_data,
    output logic                    rd_wr,
    div_if.requester                div,
    output logic [rv_pkg::xlen-1:0] bus_addr,
    output logic [rv_pkg::xlen-1:0] bus_wrdata,
    output logic                    bus_wren,
    output logic                    bus_strobe,
    input  logic                    bus_wait,
    input  logic [rv_pkg::xlen-1:0] bus_rddata
);
    import rv_pkg::*;

    state_t          q_state, d_state;
    logic [xlen-1:0] q_pc, d_pc;
    logic [xlen-1:0] q_addr, d_addr;
    logic            q_wren, d_wren;
    logic            q_stb, d_stb;
    logic [xlen-1:0] q_wrdata;
    instr_t          q_instr;
    logic            fetch_done;
    logic            go_fetch;
    logic [xlen-1:0] fetch_pc;
    logic [xlen-1:0] iw;

    assign bus_addr   = q_addr;
    assign bus_wrdata = q_wrdata;
    assign bus_wren   = q_wren;
    assign bus_strobe = q_stb;

    // Decode straight off the bus in the cycle the fetch completes
    assign fetch_done = q_state == st_fetch && !bus_wait;
    assign instr      = fetch_done ? bus_rddata : q_instr;
    assign iw         = instr;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////
    logic is_lui, is_auipc, is_jal, is_jalr, is_load, is_store;
    logic is_alu_imm, is_alu_reg, is_div, is_mul, writes_rd;
    logic [xlen-1:0] imm_u, imm_j, imm_b, pc_plus4, pc_plus_imm;

    assign is_lui     = instr.r.opcode == op_lui;
    assign is_auipc   = instr.r.opcode == op_auipc;
    assign is_jal     = instr.r.opcode == op_jal;
    assign is_jalr    = instr.r.opcode == op_jalr;
    assign is_load    = instr.r.opcode == op_load;
    assign is_store   = instr.r.opcode == op_store;
    assign is_alu_imm = instr.r.opcode == op_alu_imm;
    assign is_alu_reg = instr.r.opcode == op_alu_reg;
    assign is_div     = is_alu_reg && instr.r.funct7[0] && instr.r.funct3[2];
    assign is_mul     = is_alu_reg && instr.r.funct7[0] && !instr.r.funct3[2];  // No multiplier
    assign writes_rd  = is_lui || is_auipc || is_jal || is_jalr || is_alu_imm
                        || (is_alu_reg && !is_mul);

    assign imm_u = {iw[31:12], 12'b0};
    assign imm_j = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
    assign imm_b = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};

    assign pc_plus4    = q_pc + 32'd4;
    assign pc_plus_imm = q_pc + (is_jal ? imm_j : (is_auipc ? imm_u : imm_b));

    assign div.is_signed = !instr.r.funct3[0];
    assign div.dividend  = rs1_data;
    assign div.divisor   = rs2_data;

    always_comb begin
        if (q_state == st_div) begin
            rd_data = instr.r.funct3[1] ? div.remainder : div.quotient;
        end else if (q_state == st_mem_rd) begin
            rd_data = bus_rddata;
        end else if (is_lui) begin
            rd_data = imm_u;
        end else if (is_auipc) begin
            rd_data = pc_plus_imm;
        end else if (is_jal || is_jalr) begin
            rd_data = pc_plus4;                 // Link address
        end else begin
            rd_data = alu_result;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        d_state   = q_state;
        d_pc      = q_pc;
        d_addr    = q_addr;
        d_wren    = q_wren;
        d_stb     = q_stb;
        rd_wr     = 1'b0;
        div.start = 1'b0;
        go_fetch  = 1'b0;
        fetch_pc  = pc_plus4;

        case (q_state)
            st_fetch: begin
                if (!bus_wait) begin
                    d_stb = 1'b0;
                    if (is_div) begin
                        div.start = 1'b1;
                        d_state   = st_div;
                    end else if (is_load || is_store) begin
                        d_state = is_load ? st_mem_rd : st_mem_wr;
                        d_addr  = {sum[xlen-1:2], 2'b00};
                        d_wren  = is_store;
                        d_stb   = 1'b1;
                    end else begin
                        rd_wr    = writes_rd;   // Unknown opcodes just advance
                        go_fetch = 1'b1;
                        if (is_jal || take_branch) begin
                            fetch_pc = pc_plus_imm;
                        end else if (is_jalr) begin
                            fetch_pc = sum;
                        end
                    end
                end
            end
            st_div: begin
                if (!div.busy) begin
                    rd_wr    = 1'b1;
                    go_fetch = 1'b1;
                end
            end
            st_mem_rd: begin
                if (!bus_wait) begin
                    rd_wr    = 1'b1;
                    go_fetch = 1'b1;
                end
            end
            st_mem_wr: begin
                go_fetch = !bus_wait;
            end
        endcase

        if (go_fetch) begin
            d_state = st_fetch;
            d_pc    = {fetch_pc[xlen-1:2], 2'b00};
            d_addr  = {fetch_pc[xlen-1:2], 2'b00};
            d_wren  = 1'b0;
            d_stb   = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_state <= st_fetch;
            q_pc    <= vec_reset;
            q_addr  <= vec_reset;
            q_wren  <= 1'b0;
            q_stb   <= 1'b1;                    // First fetch starts out of reset
        end else begin
            q_state <= d_state;
            q_pc    <= d_pc;
            q_addr  <= d_addr;
            q_wren  <= d_wren;
            q_stb   <= d_stb;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            q_instr <= bus_rddata;
            if (is_store) begin
                q_wrdata <= rs2_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: rv_core.sv
`default_nettype none

module rv_core (
    input  logic                    clk,
    input  logic                    reset,
    output logic [rv_pkg::xlen-1:0] bus_addr,
    output logic [rv_pkg::xlen-1:0] bus_wrdata,
    output logic                    bus_wren,
    output logic                    bus_strobe,
    input  logic                    bus_wait,
    input  logic [rv_pkg::xlen-1:0] bus_rddata
);
    import rv_pkg::*;

    instr_t          instr;             // Current instruction word
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] sum;               // rs1 + immediate
    logic            take_branch;
    logic [xlen-1:0] rd_data;
    logic            rd_wr;

    div_if div_bus ();

    rv_control control_i (
        .clk,
        .reset,
        .instr,
        .rs1_data,
        .rs2_data,
        .alu_result,
        .sum,
        .take_branch,
        .rd_data,
        .rd_wr,
        .div        (div_bus.requester),
        .bus_addr,
        .bus_wrdata,
        .bus_wren,
        .bus_strobe,
        .bus_wait,
        .bus_rddata
    );

    rv_regfile regfile_i (
        .clk,
        .instr,
        .rd_data,
        .rd_wr,
        .rs1_data,
        .rs2_data
    );

    rv_alu alu_i (
        .instr,
        .rs1_data,
        .rs2_data,
        .alu_result,
        .sum,
        .take_branch
    );

    rv_divider divider_i (
        .clk,
        .reset,
        .div (div_bus.divider)
    );

endmodule

`default_nettype wire

// File: rv_core_chk.sv
`default_nettype none

module rv_core_chk (
    input logic                    clk,
    input logic                    reset,
    input logic [rv_pkg::xlen-1:0] bus_addr,
    input logic [rv_pkg::xlen-1:0] bus_wrdata,
    input logic                    bus_wren,
    input logic                    bus_strobe,
    input logic                    bus_wait,
    input logic                    div_start,
    input logic                    div_busy,
    input rv_pkg::state_t          state
);
    import rv_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////////////////////////////////////////
    hold_req: assert property (@(posedge clk) disable iff (reset)
        bus_strobe && bus_wait |=> bus_strobe && $stable(bus_addr) && $stable(bus_wren))
        else $error("bus request changed while bus_wait was high");

    hold_data: assert property (@(posedge clk) disable iff (reset)
        bus_strobe && bus_wren && bus_wait |=> $stable(bus_wrdata))
        else $error("write data changed while bus_wait was high");

    wren_strobe: assert property (@(posedge clk) disable iff (reset)
        bus_wren |-> bus_strobe)
        else $error("bus_wren high without bus_strobe");

    ////////////////////////////////////////////////////////////////////////////
    // Divider timing
    ////////////////////////////////////////////////////////////////////////////
    busy_state: assert property (@(posedge clk) disable iff (reset)
        div_busy |-> state == st_div)
        else $error("divider busy while the control unit left the divide state");

    start_idle: assert property (@(posedge clk) disable iff (reset)
        div_start |-> !div_busy)
        else $error("divide started while the divider was busy");

    busy_len: assert property (@(posedge clk) disable iff (reset)
        $past(div_start, 34) |-> $fell(div_busy))
        else $error("busy did not fall 33 cycles after start");

    busy_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(div_busy) |-> $past(div_start, 34))
        else $error("busy fell at the wrong cycle");

endmodule

bind rv_core rv_core_chk chk_i (
    .clk,
    .reset,
    .bus_addr,
    .bus_wrdata,
    .bus_wren,
    .bus_strobe,
    .bus_wait,
    .div_start (div_bus.start),
    .div_busy  (div_bus.busy),
    .state     (control_i.q_state)
);

`default_nettype wire

// File: tb_rv_core.sv
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    logic            clk;
    logic            reset;
    logic [xlen-1:0] bus_addr;
    logic [xlen-1:0] bus_wrdata;
    logic            bus_wren;
    logic            bus_strobe;
    logic            bus_wait;
    logic [xlen-1:0] bus_rddata;

    logic [31:0] mem [4096];            // Word memory based at address 0
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] pair_a [8];
    logic [31:0] pair_b [8];
    int unsigned prog_ptr;              // Next program word
    logic [31:0] spin_addr;
    int          spin_fetches;
    int          store_count;
    int          cycle_count;
    bit          first_done;

    rv_core dut_i (
        .clk,
        .reset,
        .bus_addr,
        .bus_wrdata,
        .bus_wren,
        .bus_strobe,
        .bus_wait,
        .bus_rddata
    );

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, op_alu_reg};   // x3 = x1 op x2
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] jal_word(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // Operation index order: add sub slt sltu xor sra sll div divu rem remu
    function automatic logic [31:0] alu_word(input int op);
        case (op)
            0:       return r_type(7'h00, 3'b000);
            1:       return r_type(7'h20, 3'b000);
            2:       return r_type(7'h00, 3'b010);
            3:       return r_type(7'h00, 3'b011);
            4:       return r_type(7'h00, 3'b100);
            5:       return r_type(7'h20, 3'b101);
            6:       return r_type(7'h00, 3'b001);
            7:       return r_type(7'h01, 3'b100);
            8:       return r_type(7'h01, 3'b101);
            9:       return r_type(7'h01, 3'b110);
            default: return r_type(7'h01, 3'b111);
        endcase
    endfunction

    // RV32IM results, with the divide-by-zero and overflow cases of the spec
    function automatic logic [31:0] model_op(input int op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               ovf;
        logic [31:0]        res;
        sa  = a;
        sb  = b;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            0: res = a + b;
            1: res = a - b;
            2: res = (sa < sb) ? 32'd1 : 32'd0;
            3: res = (a < b) ? 32'd1 : 32'd0;
            4: res = a ^ b;
            5: res = sa >>> b[4:0];
            6: res = a << b[4:0];
            7: begin
                if (b == 0) res = 32'hffff_ffff;
                else if (ovf) res = 32'h8000_0000;
                else res = sa / sb;
            end
            8: res = (b == 0) ? 32'hffff_ffff : a / b;
            9: begin
                if (b == 0) res = a;
                else if (ovf) res = 32'h0;
                else res = sa % sb;
            end
            default: res = (b == 0) ? a : a % b;
        endcase
        return res;
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[prog_ptr] = word;
        prog_ptr++;
    endtask

    task automatic push_expected(input logic [31:0] addr, input logic [31:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Program and expected stores
    ////////////////////////////////////////////////////////////////////////////
    task automatic build_program();
        logic [31:0] res_addr;
        int unsigned loop_ptr;
        int unsigned jal_ptr;
        for (int w = 0; w < 4096; w++) begin
            mem[w] = 32'h5a00_0000 ^ (w * 32'h0001_0101);   // Unique per word
        end
        for (int p = 0; p < 3; p++) begin
            pair_a[p] = $urandom;
            pair_b[p] = $urandom;
        end
        pair_a[3] = $urandom;
        pair_b[3] = $urandom_range(1000, 1);
        pair_a[4] = $urandom;
        pair_b[4] = -$urandom_range(1000, 1);
        pair_a[5] = $urandom;
        pair_b[5] = 32'h0;                          // Divide by zero
        pair_a[6] = 32'h8000_0000;                  // Signed overflow
        pair_b[6] = 32'hffff_ffff;
        pair_a[7] = 32'hffff_fff9;
        pair_b[7] = 32'h0000_0002;

        prog_ptr = vec_reset[13:2];
        res_addr = 32'h0000_2000;
        emit(lui_word(20'h00001, 5'd10));           // Operand table at 0x1000
        emit(lui_word(20'h00002, 5'd11));           // Result area at 0x2000
        emit(32'h0000_000b);                        // Custom opcode, no-op
        for (int p = 0; p < 8; p++) begin
            mem[1024 + 2*p]     = pair_a[p];
            mem[1024 + 2*p + 1] = pair_b[p];
            emit(i_type(32'd0, 5'd10, 3'b010, 5'd1, op_load));
            emit(i_type(32'd4, 5'd10, 3'b010, 5'd2, op_load));
            for (int op = 0; op < 11; op++) begin
                emit(alu_word(op));
                emit(s_type(op * 4, 5'd3, 5'd11));
                push_expected(res_addr, model_op(op, pair_a[p], pair_b[p]));
                res_addr += 4;
            end
            emit(i_type(32'd8, 5'd10, 3'b000, 5'd10, op_alu_imm));
            emit(i_type(32'd44, 5'd11, 3'b000, 5'd11, op_alu_imm));
        end

        // Countdown loop stores 4 down to 0
        emit(i_type(32'd5, 5'd0, 3'b000, 5'd5, op_alu_imm));
        loop_ptr = prog_ptr;
        emit(i_type(32'hffff_ffff, 5'd5, 3'b000, 5'd5, op_alu_imm));
        emit(s_type(32'd0, 5'd5, 5'd11));
        emit(i_type(32'd4, 5'd11, 3'b000, 5'd11, op_alu_imm));
        emit(b_type((loop_ptr - prog_ptr) * 4, 5'd0, 5'd5, 3'b001));
        for (int n = 4; n >= 0; n--) begin
            push_expected(res_addr, n);
            res_addr += 4;
        end

        jal_ptr = prog_ptr;
        emit(jal_word(32'd8, 5'd6));
        emit(s_type(32'd0, 5'd0, 5'd11));           // Jumped over
        emit(s_type(32'd0, 5'd6, 5'd11));
        push_expected(res_addr, jal_ptr * 4 + 4);
        spin_addr = prog_ptr * 4;
        emit(jal_word(32'd0, 5'd0));
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        int unsigned seed_ret;
        seed_ret     = $urandom(94);
        reset        = 1'b1;
        bus_wait     = 1'b0;
        bus_rddata   = '0;
        spin_fetches = 0;
        store_count  = 0;
        cycle_count  = 0;
        first_done   = 1'b0;
        build_program();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("strobe after reset", {31'b0, bus_strobe}, 32'd1);
        check_value("write enable after reset", {31'b0, bus_wren}, 32'd0);
        check_value("address after reset", bus_addr, vec_reset);
        wait (spin_fetches >= 2);
        if (exp_addr_q.size() != 0) begin
            fail_run($sformatf("%0d expected stores never reached the bus", exp_addr_q.size()));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    // Memory answers one unit after the edge
    always @(posedge clk) begin
        #1;
        bus_wait   = ($urandom % 3) == 0;           // About one stall in three
        bus_rddata = mem[bus_addr[13:2]];
    end

    // Transfers that complete at the coming edge
    always @(negedge clk) begin
        if (!reset && bus_strobe && !bus_wait) begin
            if (!first_done) begin
                check_value("first transfer write enable", {31'b0, bus_wren}, 32'd0);
                check_value("first transfer address", bus_addr, vec_reset);
                first_done = 1'b1;
            end
            if (bus_wren) begin
                mem[bus_addr[13:2]] = bus_wrdata;
                if (exp_addr_q.size() == 0) begin
                    fail_run("the core stored a word after the last expected store");
                end else begin
                    check_value($sformatf("store %0d address", store_count), bus_addr,
                                exp_addr_q.pop_front());
                    check_value($sformatf("store %0d data", store_count), bus_wrdata,
                                exp_data_q.pop_front());
                    store_count++;
                end
            end else if (bus_addr == spin_addr) begin
                spin_fetches++;
            end
        end
    end

    // About 1700 cycles expected, 20000 is a wide margin
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > 20000) begin
            fail_run("the program did not reach its final loop within 20000 cycles");
        end
    end

endmodule

`default_nettype wire

// File: project.f
rv_pkg.sv
div_if.sv
rv_regfile.sv
rv_alu.sv
rv_divider.sv
rv_control.sv
rv_core.sv
rv_core_chk.sv
tb_rv_core.sv
